// File: design/rsa_pkg.sv
// rsa compute core package
// sizes, bank map and shared types
package rsa_pkg;

  // data word width
  localparam int RSA_DW = 16;

  // array geometry, rows by columns
  localparam int X = 4;
  localparam int Y = 4;
  // one bank lane per array row
  localparam int L = X;
  // inner dimension of A times B
  localparam int N_K = 4;

  // 64 words per lane
  localparam int TB_AW = 6;

  typedef logic [RSA_DW-1:0] data_t;
  typedef logic [TB_AW-1:0]  addr_t;
  typedef logic [1:0]        lane_t;

  // stage operation
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_MAC = 1'b1
  } op_e;

  // operand and result areas in every lane
  localparam addr_t A_BASE = 6'd0;
  localparam addr_t B_BASE = 6'd8;
  localparam addr_t M_BASE = 6'd16;
  localparam addr_t C_BASE = 6'd24;

  // one drain shift per array column
  localparam int DRAIN_LEN = Y;
  // wait after the last feed read until PE(X-1,Y-1) takes its last product
  localparam int FLUSH_LEN = X + Y;

endpackage

// File: design/temp_bank.sv
// temporary bank lane
// true dual port, registered reads
module temp_bank (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_ena,
  input  logic           i_wea,
  input  rsa_pkg::addr_t i_addra,
  input  rsa_pkg::data_t i_dina,
  output rsa_pkg::data_t o_douta,
  input  logic           i_enb,
  input  logic           i_web,
  input  rsa_pkg::addr_t i_addrb,
  input  rsa_pkg::data_t i_dinb,
  output rsa_pkg::data_t o_doutb
);

  rsa_pkg::data_t mem [2**rsa_pkg::TB_AW];

  // writes from both ports
  // controller never targets one word from both ports at once
  always_ff @(posedge clk) begin
    if (i_ena && i_wea) begin
      mem[i_addra] <= i_dina;
    end
    if (i_enb && i_web) begin
      mem[i_addrb] <= i_dinb;
    end
  end

  // read first, old word comes out on a write
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_douta <= '0;
      o_doutb <= '0;
    end else begin
      if (i_ena) begin
        o_douta <= mem[i_addra];
      end
      if (i_enb) begin
        o_doutb <= mem[i_addrb];
      end
    end
  end

endmodule

// File: design/operand_skew.sv
// operand skew feed
// lane i arrives i cycles after lane 0
module operand_skew #(
  parameter int LANES = rsa_pkg::X
) (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_en,
  input  rsa_pkg::data_t i_lane_data [LANES],
  output rsa_pkg::data_t o_lane_data [LANES]
);

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // stage 0 captures the bank word, stages 1..i only delay
    rsa_pkg::data_t pipe [i+1];

    always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        for (int j = 0; j <= i; j++) begin
          pipe[j] <= '0;
        end
      end else begin
        // zero outside the feed window keeps idle products at zero
        if (i_en) begin
          pipe[0] <= i_lane_data[i];
        end else begin
          pipe[0] <= '0;
        end
        for (int j = 1; j <= i; j++) begin
          pipe[j] <= pipe[j-1];
        end
      end
    end

    // latency 1 + i
    assign o_lane_data[i] = pipe[i];
  end

endmodule

// File: design/pe_mac.sv
// multiply-accumulate processing element
module pe_mac (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic           i_cal_en,
  input  rsa_pkg::data_t i_west,
  input  rsa_pkg::data_t i_south,
  input  logic           i_drain,
  input  rsa_pkg::data_t i_din,
  output rsa_pkg::data_t o_east,
  output rsa_pkg::data_t o_north,
  output rsa_pkg::data_t o_dout
);

  rsa_pkg::data_t acc_q;
  rsa_pkg::data_t prod;

  // low 16 bits of the product only
  assign prod = i_west * i_south;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_east  <= '0;
      o_north <= '0;
      acc_q   <= '0;
    end else begin
      // operands hop one PE per cycle
      o_east  <= i_west;
      o_north <= i_south;
      // clear wins, then drain, then accumulate
      if (i_clear) begin
        acc_q <= '0;
      end else if (i_drain) begin
        // take the right neighbor result
        acc_q <= i_din;
      end else if (i_cal_en) begin
        acc_q <= acc_q + prod;
      end
    end
  end

  // accumulator feeds the left neighbor on a drain
  assign o_dout = acc_q;

endmodule

// File: design/pe_array.sv
// output-stationary pe grid
// leftward drain and per-row m adder
module pe_array (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_clear,
  input  logic           i_cal_en,
  input  logic           i_drain,
  input  logic           i_m_add,
  input  rsa_pkg::data_t i_west   [rsa_pkg::X],
  input  rsa_pkg::data_t i_south  [rsa_pkg::Y],
  input  rsa_pkg::data_t i_m_data [rsa_pkg::X],
  output rsa_pkg::data_t o_c_data [rsa_pkg::X]
);

  // hor[r][c] is the west operand of PE(r,c)
  rsa_pkg::data_t hor [rsa_pkg::X][rsa_pkg::Y+1];
  // ver[r][c] is the south operand of PE(r,c), row 0 at the bottom
  rsa_pkg::data_t ver [rsa_pkg::X+1][rsa_pkg::Y];
  // drn[r][c] is the accumulator of PE(r,c)
  rsa_pkg::data_t drn [rsa_pkg::X][rsa_pkg::Y+1];

  for (genvar r = 0; r < rsa_pkg::X; r++) begin : g_row
    // A enters at the left edge
    assign hor[r][0] = i_west[r];
    // nothing to the right of the last column
    assign drn[r][rsa_pkg::Y] = '0;

    for (genvar c = 0; c < rsa_pkg::Y; c++) begin : g_col
      pe_mac u_pe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_clear  (i_clear),
        .i_cal_en (i_cal_en),
        .i_west   (hor[r][c]),
        .i_south  (ver[r][c]),
        .i_drain  (i_drain),
        .i_din    (drn[r][c+1]),
        .o_east   (hor[r][c+1]),
        .o_north  (ver[r+1][c]),
        .o_dout   (drn[r][c])
      );
    end

    // column 0 leaves the array, plus M row word for OP_MAC
    always_ff @(posedge clk) begin
      if (i_m_add) begin
        o_c_data[r] <= drn[r][0] + i_m_data[r];
      end else begin
        o_c_data[r] <= drn[r][0];
      end
    end
  end

  // B enters at the bottom edge
  for (genvar c = 0; c < rsa_pkg::Y; c++) begin : g_bot
    assign ver[0][c] = i_south[c];
  end

endmodule

// File: design/pe_config.sv
// stage controller
// handshakes, host arbitration, bank sequencing
module pe_config (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_stage_val,
  output logic                   o_stage_rdy,
  input  rsa_pkg::op_e           i_stage_op,
  output logic                   o_cplt_val,
  input  logic                   i_cplt_rdy,
  input  logic                   i_host_wr,
  input  logic                   i_host_rd,
  input  rsa_pkg::lane_t         i_host_lane,
  input  rsa_pkg::addr_t         i_host_addr,
  output logic                   o_host_rval,
  output logic                   o_tb_ena,
  output logic [rsa_pkg::L-1:0]  o_tb_wea,
  output rsa_pkg::addr_t         o_tb_addra,
  output logic                   o_tb_enb,
  output logic [rsa_pkg::L-1:0]  o_tb_web,
  output rsa_pkg::addr_t         o_tb_addrb,
  output logic                   o_skew_en,
  output logic                   o_pe_clear,
  output logic                   o_pe_cal_en,
  output logic                   o_pe_drain,
  output logic                   o_m_add
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FEED,
    S_FLUSH,
    S_DRAIN,
    S_DONE
  } state_t;

  state_t       state_q;
  state_t       state_d;
  logic [3:0]   cnt_q;
  rsa_pkg::op_e op_q;
  logic         accept;
  logic         last_feed;
  logic         last_flush;
  logic         last_drain;

  assign o_stage_rdy = (state_q == S_IDLE);
  assign o_cplt_val  = (state_q == S_DONE);
  assign accept      = i_stage_val && o_stage_rdy;

  // cnt counts cycles inside the current state
  assign last_feed  = (cnt_q == 4'(rsa_pkg::N_K - 1));
  assign last_flush = (cnt_q == 4'(rsa_pkg::FLUSH_LEN - 1));
  // one extra cycle writes the last C column
  assign last_drain = (cnt_q == 4'(rsa_pkg::DRAIN_LEN));

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (accept) state_d = S_FEED;
      S_FEED:  if (last_feed) state_d = S_FLUSH;
      S_FLUSH: if (last_flush) state_d = S_DRAIN;
      S_DRAIN: if (last_drain) state_d = S_DONE;
      // back-pressure holds here
      S_DONE:  if (i_cplt_rdy) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q     <= S_IDLE;
      cnt_q       <= '0;
      op_q        <= rsa_pkg::OP_MUL;
      o_skew_en   <= 1'b0;
      o_host_rval <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 4'd1;
      end
      if (accept) begin
        op_q <= i_stage_op;
      end
      // feed words leave the bank one cycle after their address
      o_skew_en   <= (state_q == S_FEED);
      // host read data is out of the bank next cycle
      o_host_rval <= o_stage_rdy && i_host_rd;
    end
  end

  always_comb begin
    o_tb_ena    = 1'b0;
    o_tb_wea    = '0;
    o_tb_addra  = i_host_addr;
    o_tb_enb    = 1'b0;
    o_tb_web    = '0;
    o_tb_addrb  = rsa_pkg::C_BASE;
    o_pe_clear  = 1'b0;
    o_pe_cal_en = 1'b0;
    o_pe_drain  = 1'b0;
    o_m_add     = 1'b0;
    case (state_q)
      S_IDLE: begin
        // host owns port A
        o_tb_ena = i_host_wr || i_host_rd;
        for (int i = 0; i < rsa_pkg::L; i++) begin
          o_tb_wea[i] = i_host_wr && (i_host_lane == rsa_pkg::lane_t'(i));
        end
      end
      S_FEED: begin
        // A[r][k] on port A, B[k][c] on port B, all lanes
        o_tb_ena    = 1'b1;
        o_tb_enb    = 1'b1;
        o_tb_addra  = rsa_pkg::A_BASE + rsa_pkg::addr_t'(cnt_q);
        o_tb_addrb  = rsa_pkg::B_BASE + rsa_pkg::addr_t'(cnt_q);
        o_pe_clear  = (cnt_q == 4'd0);
        o_pe_cal_en = 1'b1;
      end
      S_FLUSH: begin
        // wavefront still crossing, skew zeroes fill behind it
        o_pe_cal_en = 1'b1;
        // first M column arrives with the first drain cycle
        if (last_flush) begin
          o_tb_ena   = 1'b1;
          o_tb_addra = rsa_pkg::M_BASE;
        end
      end
      S_DRAIN: begin
        if (cnt_q < 4'(rsa_pkg::DRAIN_LEN)) begin
          o_pe_drain = 1'b1;
          o_m_add    = (op_q == rsa_pkg::OP_MAC);
        end
        // M column c+1 read one cycle ahead of its use
        if (cnt_q < 4'(rsa_pkg::DRAIN_LEN - 1)) begin
          o_tb_ena   = 1'b1;
          o_tb_addra = rsa_pkg::M_BASE + rsa_pkg::addr_t'(cnt_q + 4'd1);
        end
        // C column c is in the adder register one cycle after its drain
        if (cnt_q != 4'd0) begin
          o_tb_enb   = 1'b1;
          o_tb_web   = '1;
          o_tb_addrb = rsa_pkg::C_BASE + rsa_pkg::addr_t'(cnt_q - 4'd1);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: design/rsa_top.sv
// rsa compute core top
module rsa_top (
  input  logic           clk,
  input  logic           i_arst_n,
  input  logic           i_stage_val,
  output logic           o_stage_rdy,
  input  rsa_pkg::op_e   i_stage_op,
  output logic           o_cplt_val,
  input  logic           i_cplt_rdy,
  input  logic           i_host_wr,
  input  logic           i_host_rd,
  input  rsa_pkg::lane_t i_host_lane,
  input  rsa_pkg::addr_t i_host_addr,
  input  rsa_pkg::data_t i_host_wdata,
  output rsa_pkg::data_t o_host_rdata [rsa_pkg::L],
  output logic           o_host_rval
);

  logic                  tb_ena;
  logic [rsa_pkg::L-1:0] tb_wea;
  rsa_pkg::addr_t        tb_addra;
  logic                  tb_enb;
  logic [rsa_pkg::L-1:0] tb_web;
  rsa_pkg::addr_t        tb_addrb;
  rsa_pkg::data_t        tb_douta [rsa_pkg::L];
  rsa_pkg::data_t        tb_doutb [rsa_pkg::L];
  rsa_pkg::data_t        a_skew   [rsa_pkg::X];
  rsa_pkg::data_t        b_skew   [rsa_pkg::Y];
  rsa_pkg::data_t        c_data   [rsa_pkg::X];
  logic                  skew_en;
  logic                  pe_clear;
  logic                  pe_cal_en;
  logic                  pe_drain;
  logic                  m_add;

  // one bank lane per row, host data on every port A
  for (genvar i = 0; i < rsa_pkg::L; i++) begin : g_bank
    temp_bank u_bank (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_ena    (tb_ena),
      .i_wea    (tb_wea[i]),
      .i_addra  (tb_addra),
      .i_dina   (i_host_wdata),
      .o_douta  (tb_douta[i]),
      .i_enb    (tb_enb),
      .i_web    (tb_web[i]),
      .i_addrb  (tb_addrb),
      .i_dinb   (c_data[i]),
      .o_doutb  (tb_doutb[i])
    );
  end

  // host picks its lane from the per-lane port A words
  assign o_host_rdata = tb_douta;

  // A rows from port A
  operand_skew #(.LANES(rsa_pkg::X)) u_a_skew (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_en        (skew_en),
    .i_lane_data (tb_douta),
    .o_lane_data (a_skew)
  );

  // B columns from port B
  operand_skew #(.LANES(rsa_pkg::Y)) u_b_skew (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_en        (skew_en),
    .i_lane_data (tb_doutb),
    .o_lane_data (b_skew)
  );

  // M words share port A with the feed
  pe_array u_array (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clear  (pe_clear),
    .i_cal_en (pe_cal_en),
    .i_drain  (pe_drain),
    .i_m_add  (m_add),
    .i_west   (a_skew),
    .i_south  (b_skew),
    .i_m_data (tb_douta),
    .o_c_data (c_data)
  );

  pe_config u_config (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_stage_val (i_stage_val),
    .o_stage_rdy (o_stage_rdy),
    .i_stage_op  (i_stage_op),
    .o_cplt_val  (o_cplt_val),
    .i_cplt_rdy  (i_cplt_rdy),
    .i_host_wr   (i_host_wr),
    .i_host_rd   (i_host_rd),
    .i_host_lane (i_host_lane),
    .i_host_addr (i_host_addr),
    .o_host_rval (o_host_rval),
    .o_tb_ena    (tb_ena),
    .o_tb_wea    (tb_wea),
    .o_tb_addra  (tb_addra),
    .o_tb_enb    (tb_enb),
    .o_tb_web    (tb_web),
    .o_tb_addrb  (tb_addrb),
    .o_skew_en   (skew_en),
    .o_pe_clear  (pe_clear),
    .o_pe_cal_en (pe_cal_en),
    .o_pe_drain  (pe_drain),
    .o_m_add     (m_add)
  );

endmodule

// File: bench/rsa_top_tb.sv
// rsa compute core testbench
module rsa_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 5;
  // op word plus A, B, M and C
  localparam int TEST_WORDS = 1 + 4 * 16;

  logic           clk;
  logic           i_arst_n;
  logic           i_stage_val;
  logic           o_stage_rdy;
  rsa_pkg::op_e   i_stage_op;
  logic           o_cplt_val;
  logic           i_cplt_rdy;
  logic           i_host_wr;
  logic           i_host_rd;
  rsa_pkg::lane_t i_host_lane;
  rsa_pkg::addr_t i_host_addr;
  rsa_pkg::data_t i_host_wdata;
  rsa_pkg::data_t o_host_rdata [rsa_pkg::L];
  logic           o_host_rval;

  rsa_pkg::data_t pat [NUM_TESTS*TEST_WORDS];
  rsa_pkg::data_t shadow [rsa_pkg::L][2**rsa_pkg::TB_AW];
  logic [31:0]    rng;
  int             data_errs;
  int             flag_errs;
  int             other_errs;

  rsa_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // steps the shared generator
  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic check_data(input string name, input rsa_pkg::data_t exp,
                            input rsa_pkg::data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("** Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  // all host tasks start and end on a falling edge
  task automatic host_write(input rsa_pkg::lane_t lane, input rsa_pkg::addr_t addr,
                            input rsa_pkg::data_t data);
    i_host_wr    = 1'b1;
    i_host_lane  = lane;
    i_host_addr  = addr;
    i_host_wdata = data;
    @(negedge clk);
    i_host_wr = 1'b0;
  endtask

  // rval low before, high one cycle after the read, then low again
  task automatic read_expect(input string name, input rsa_pkg::lane_t lane,
                             input rsa_pkg::addr_t addr, input rsa_pkg::data_t exp);
    check_flag({name, " rval before read"}, 1'b0, o_host_rval);
    i_host_rd   = 1'b1;
    i_host_lane = lane;
    i_host_addr = addr;
    @(negedge clk);
    check_flag({name, " rval"}, 1'b1, o_host_rval);
    check_data(name, exp, o_host_rdata[lane]);
    i_host_rd = 1'b0;
    @(negedge clk);
  endtask

  // random words at random lanes and upper addresses
  task automatic bank_round_trip();
    rsa_pkg::lane_t lanes [16];
    rsa_pkg::addr_t addrs [16];
    for (int i = 0; i < 16; i++) begin
      lanes[i] = rsa_pkg::lane_t'(next_rand());
      addrs[i] = rsa_pkg::addr_t'(32 + next_rand() % 32);
      shadow[lanes[i]][addrs[i]] = rsa_pkg::data_t'(next_rand());
      host_write(lanes[i], addrs[i], shadow[lanes[i]][addrs[i]]);
    end
    // a repeated slot reads its last write
    for (int i = 0; i < 16; i++) begin
      read_expect($sformatf("round trip %0d", i), lanes[i], addrs[i],
                  shadow[lanes[i]][addrs[i]]);
    end
  endtask

  task automatic load_operands(input int t);
    int base;
    base = t * TEST_WORDS + 1;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        // A[i][j] in lane i
        host_write(rsa_pkg::lane_t'(i), rsa_pkg::A_BASE + rsa_pkg::addr_t'(j),
                   pat[base + i*4 + j]);
        // B[i][j] in lane j at row address i
        host_write(rsa_pkg::lane_t'(j), rsa_pkg::B_BASE + rsa_pkg::addr_t'(i),
                   pat[base + 16 + i*4 + j]);
        host_write(rsa_pkg::lane_t'(i), rsa_pkg::M_BASE + rsa_pkg::addr_t'(j),
                   pat[base + 32 + i*4 + j]);
        // junk in C so a missing writeback shows
        host_write(rsa_pkg::lane_t'(i), rsa_pkg::C_BASE + rsa_pkg::addr_t'(j),
                   rsa_pkg::data_t'(next_rand()));
      end
    end
  endtask

  task automatic run_stage(input int t);
    rsa_pkg::op_e op;
    string        tag;
    int           hold;
    op  = rsa_pkg::op_e'(pat[t*TEST_WORDS][0]);
    tag = $sformatf("test %0d", t);
    i_stage_op  = op;
    i_stage_val = 1'b1;
    @(negedge clk);
    i_stage_val = 1'b0;
    check_flag({tag, " stage_rdy after accept"}, 1'b0, o_stage_rdy);
    // busy host traffic into the A area is dropped
    while (!o_cplt_val) begin
      check_flag({tag, " stage_rdy while busy"}, 1'b0, o_stage_rdy);
      check_flag({tag, " rval while busy"}, 1'b0, o_host_rval);
      i_host_rd    = 1'b1;
      i_host_wr    = 1'b1;
      i_host_lane  = rsa_pkg::lane_t'(next_rand());
      i_host_addr  = rsa_pkg::A_BASE + rsa_pkg::addr_t'(next_rand() % 4);
      i_host_wdata = rsa_pkg::data_t'(next_rand());
      @(negedge clk);
    end
    // back-pressure with a second stage on offer
    hold = 1 + int'(next_rand() % 8);
    for (int i = 0; i < hold; i++) begin
      check_flag({tag, " cplt_val held"}, 1'b1, o_cplt_val);
      check_flag({tag, " stage_rdy held"}, 1'b0, o_stage_rdy);
      check_flag({tag, " rval while held"}, 1'b0, o_host_rval);
      i_stage_val = 1'b1;
      i_stage_op  = (op == rsa_pkg::OP_MUL) ? rsa_pkg::OP_MAC : rsa_pkg::OP_MUL;
      @(negedge clk);
    end
    check_flag({tag, " cplt_val before release"}, 1'b1, o_cplt_val);
    check_flag({tag, " rval before release"}, 1'b0, o_host_rval);
    i_stage_val = 1'b0;
    i_host_rd   = 1'b0;
    i_host_wr   = 1'b0;
    i_cplt_rdy  = 1'b1;
    @(negedge clk);
    i_cplt_rdy = 1'b0;
    check_flag({tag, " stage_rdy after release"}, 1'b1, o_stage_rdy);
    check_flag({tag, " cplt_val after release"}, 1'b0, o_cplt_val);
  endtask

  task automatic verify_results(input int t);
    int base;
    base = t * TEST_WORDS + 1;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        read_expect($sformatf("test %0d C[%0d][%0d]", t, i, j), rsa_pkg::lane_t'(i),
                    rsa_pkg::C_BASE + rsa_pkg::addr_t'(j), pat[base + 48 + i*4 + j]);
      end
    end
    // A area untouched by the busy writes
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        read_expect($sformatf("test %0d A[%0d][%0d]", t, i, j), rsa_pkg::lane_t'(i),
                    rsa_pkg::A_BASE + rsa_pkg::addr_t'(j), pat[base + i*4 + j]);
      end
    end
  endtask

  initial begin
    i_arst_n     = 1'b0;
    i_stage_val  = 1'b0;
    i_stage_op   = rsa_pkg::OP_MUL;
    i_cplt_rdy   = 1'b0;
    i_host_wr    = 1'b0;
    i_host_rd    = 1'b0;
    i_host_lane  = '0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    rng          = 32'd26;
    data_errs    = 0;
    flag_errs    = 0;
    other_errs   = 0;
    // op words above 1 mean the file did not load
    for (int i = 0; i < NUM_TESTS*TEST_WORDS; i++) begin
      pat[i] = '1;
    end
    $readmemh("bench/mac_patterns.txt", pat);
    repeat (16) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    check_flag("reset stage_rdy", 1'b1, o_stage_rdy);
    check_flag("reset cplt_val", 1'b0, o_cplt_val);
    check_flag("reset host_rval", 1'b0, o_host_rval);
    bank_round_trip();
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (pat[t*TEST_WORDS] > 16'd1) begin
        other_errs++;
        $display("test %0d has no valid op word, pattern file missing or malformed", t);
      end else begin
        load_operands(t);
        run_stage(t);
        verify_results(t);
      end
    end
    $display("errors: data %0d, flag %0d, other %0d", data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // budget per test covers loads, stage, hold and read-back
  initial begin
    repeat (NUM_TESTS * 200 + 1000) @(posedge clk);
    $display("watchdog expired after %0d cycles, run timed out", NUM_TESTS * 200 + 1000);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: rsa_top.f
design/rsa_pkg.sv
design/temp_bank.sv
design/operand_skew.sv
design/pe_mac.sv
design/pe_array.sv
design/pe_config.sv
design/rsa_top.sv
bench/rsa_top_tb.sv

// File: Makefile
# Verilator build and run of the rsa compute core testbench

VERILATOR ?= verilator
TOP       ?= rsa_top_tb
FILELIST  ?= rsa_top.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, the file list or this Makefile changes
$(SIM_BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mac_patterns.txt
// per test: op word (0 = OP_MUL, 1 = OP_MAC), then one line each for A, B, M, expected C
// 16 hex words per line, row-major, A[r][k] B[k][c] M[r][c] C[r][c]
// test 0, mul, identity A so C equals B, M ignored
0
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
1234 5678 9abc def0 0fed cba9 8765 4321 1111 2222 3333 4444 a5a5 5a5a ffff 0001
dead beef cafe f00d 0bad 1dea 7777 8888 0101 0202 0303 0404 aaaa bbbb cccc dddd
1234 5678 9abc def0 0fed cba9 8765 4321 1111 2222 3333 4444 a5a5 5a5a ffff 0001
// test 1, mac, identity A, sums wrap
1
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
0001 0002 0003 0004 0005 0006 0007 0008 fff0 fff1 fff2 fff3 8000 7fff 0100 0010
ffff fffe 0010 0020 1000 2000 3000 4000 0010 0010 0020 0100 8000 0001 0f00 1234
0000 0000 0013 0024 1005 2006 3007 4008 0000 0001 0012 00f3 0000 8000 1000 1244
// test 2, mul, small integers, M ignored
0
0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
0001 0000 0002 0001 0000 0001 0001 0002 0003 0001 0000 0001 0002 0002 0001 0000
1357 2468 9bdf ace0 ffff 0000 ffff 0000 4321 8765 cba9 0fed 0f0f f0f0 3c3c c3c3
0012 000d 0008 0008 002a 001d 0018 0018 0042 002d 0028 0028 005a 003d 0038 0038
// test 3, mac, products truncated to 16 bits
1
ffff 0000 0000 0000 0000 0002 0000 0000 0100 0100 0000 0000 0001 0001 0001 0001
0003 0010 0100 8000 0004 0020 0200 4000 0005 0030 0300 2000 0006 0040 0400 1000
0003 0011 0100 0001 1000 0fc0 fc00 8000 0100 0200 0300 0400 0001 0002 0003 0004
0000 0001 0000 8001 1008 1000 0000 0000 0800 3200 0300 0400 0013 00a2 0a03 f004
// test 4, mac, mixed operands
1
0002 0003 0000 0001 0001 0001 0001 0001 0004 0000 0002 0000 0000 0005 0000 0003
0010 0001 0007 0000 0002 0020 0000 0003 0100 0000 0004 0001 0000 0008 0002 0010
1000 2000 3000 4000 0001 0001 0001 0001 fff0 0000 ffff 0100 0a0a 0b0b 0c0c 0d0d
1026 206a 3010 4019 0113 002a 000e 0015 0230 0004 0023 0102 0a14 0bc3 0c12 0d4c
